// ==== Bender.yml ====
package:
  name: automaton

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/automaton_pkg.sv
      - hw/wb_config_port.sv
      - hw/ste_cell.sv
      - hw/activation_router.sv
      - hw/automaton_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/automaton_tb.sv

// ==== bench/automaton_tb.sv ====
`default_nettype none

`include "automaton_params.svh"

module automaton_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import automaton_pkg::*;

  localparam int CLK_PERIOD_NS = 4;
  localparam int N_FIXED       = 9;
  localparam int N_RAND        = 200;
  localparam int CFG_PER_STE   = `CLASS_WORDS + 2;
  // Reset reads, fixed config, fixed stream, clear test, random config and stream
  localparam int N_TRANS = 2 + 4 * CFG_PER_STE + N_FIXED * 2 + 1 + 5
                           + `N_STE * CFG_PER_STE + N_RAND * 2 + 1;
  localparam int WATCHDOG_NS = N_TRANS * 3 * CLK_PERIOD_NS + 2000;

  logic     clk = 1'b0;
  logic     rst;
  logic     cyc;
  logic     stb;
  logic     we;
  wb_adr_t  adr;
  wb_data_t dat_w;
  wb_data_t dat_r;
  logic     ack;
  logic     report;

  // Reference model state mirrored from config writes
  wb_data_t      ref_class [`N_STE][`CLASS_WORDS];
  ste_vec_t      ref_succ [`N_STE];
  logic          ref_start [`N_STE];
  logic          ref_report [`N_STE];
  ste_vec_t      model_active;
  report_count_t model_count;

  wb_data_t class_buf [`CLASS_WORDS];
  string    test_name = "reset";
  integer   seed = 31;
  logic     exp_report_q [$];
  logic     report_due = 1'b0;
  logic     report_exp = 1'b0;
  symbol_t  sym_pool [4] = '{8'h00, 8'h61, 8'h9e, 8'hff};  // Spread over class words
  string    fixed_stream = "xabcabcab";

  automaton_top dut_i (
    .clk    (clk),
    .rst    (rst),
    .cyc    (cyc),
    .stb    (stb),
    .we     (we),
    .adr    (adr),
    .dat_w  (dat_w),
    .dat_r  (dat_r),
    .ack    (ack),
    .report (report)
  );

  always #(CLK_PERIOD_NS / 2) clk = ~clk;

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "stopping at first error");
  endtask

  // Status words are zero-extended onto the bus
  task automatic check_active(input string name, input ste_vec_t exp, input wb_data_t act);
    if (wb_data_t'(exp) !== act) begin
      abort_run($sformatf("mismatch %s expected %0h actual %0h", name, exp, act));
    end
  endtask

  task automatic check_count(input string name, input report_count_t exp,
                             input wb_data_t act);
    if (wb_data_t'(exp) !== act) begin
      abort_run($sformatf("mismatch %s expected %0d actual %0d", name, exp, act));
    end
  endtask

  task automatic check_report(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      abort_run($sformatf("mismatch %s report expected %0b actual %0b", name, exp, act));
    end
  endtask

  // Next active vector and report bit for one symbol
  function automatic ste_vec_t ref_step(input ste_vec_t act, input symbol_t sym,
                                        output logic rep);
    ste_vec_t nxt;
    logic     in_class;
    nxt = '0;
    rep = 1'b0;
    for (int i = 0; i < `N_STE; i++) begin
      in_class = ref_class[i][sym / 32][sym % 32];
      if ((act[i] || ref_start[i]) && in_class) begin
        nxt = nxt | ref_succ[i];
        if (ref_report[i]) begin
          rep = 1'b1;
        end
      end
    end
    return nxt;
  endfunction

  task automatic wb_write(input wb_adr_t a, input wb_data_t d);
    @(posedge clk);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= 1'b1;
    adr   <= a;
    dat_w <= d;
    do @(negedge clk); while (ack !== 1'b1);
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
  endtask

  task automatic wb_read(input wb_adr_t a, output wb_data_t d);
    @(posedge clk);
    cyc <= 1'b1;
    stb <= 1'b1;
    we  <= 1'b0;
    adr <= a;
    do @(negedge clk); while (ack !== 1'b1);
    d = dat_r;  // Valid during the ack cycle
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
  endtask

  task automatic cfg_write(input int idx, input int ofs, input wb_data_t d);
    wb_write(wb_adr_t'(idx * `STE_STRIDE + ofs), d);
    if (ofs < `CLASS_WORDS) begin
      ref_class[idx][ofs] = d;
    end else if (ofs == `OFS_SUCC) begin
      ref_succ[idx] = d[`N_STE-1:0];
    end else if (ofs == `OFS_FLAGS) begin
      ref_start[idx]  = d[0];
      ref_report[idx] = d[1];
    end
  endtask

  task automatic clear_class_buf();
    for (int k = 0; k < `CLASS_WORDS; k++) begin
      class_buf[k] = '0;
    end
  endtask

  task automatic add_class_symbol(input symbol_t s);
    class_buf[s / 32][s % 32] = 1'b1;
  endtask

  task automatic program_ste(input int idx, input ste_vec_t succ, input logic start,
                             input logic rep);
    for (int k = 0; k < `CLASS_WORDS; k++) begin
      cfg_write(idx, k, class_buf[k]);
    end
    cfg_write(idx, `OFS_SUCC, wb_data_t'(succ));
    cfg_write(idx, `OFS_FLAGS, wb_data_t'({rep, start}));
  endtask

  task automatic step_and_check(input symbol_t sym);
    logic     rep;
    wb_data_t d;
    ste_vec_t nxt;
    nxt = ref_step(model_active, sym, rep);
    exp_report_q.push_back(rep);  // Consumed by the report monitor
    wb_write(`ADR_SYMBOL, wb_data_t'(sym));
    model_active = nxt;
    if (rep) begin
      model_count = model_count + 1'b1;
    end
    wb_read(`ADR_ACTIVE, d);
    check_active(test_name, model_active, d);
  endtask

  // Report must pulse only in the cycle after a symbol ack
  always @(negedge clk) begin
    if (!rst) begin
      check_report(test_name, report_due ? report_exp : 1'b0, report);
    end
    report_due = 1'b0;
    if (ack && we && adr == `ADR_SYMBOL) begin
      if (exp_report_q.size() == 0) begin
        abort_run("symbol step acknowledged with no expected report queued");
      end else begin
        report_exp = exp_report_q.pop_front();
        report_due = 1'b1;
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    abort_run("timeout, the bus stalled and the tests did not finish");
  end

  initial begin
    wb_data_t d;
    wb_data_t r;
    int       pick;
    rst   = 1'b1;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = '0;
    dat_w = '0;
    for (int i = 0; i < `N_STE; i++) begin
      for (int k = 0; k < `CLASS_WORDS; k++) begin
        ref_class[i][k] = '0;
      end
      ref_succ[i]   = '0;
      ref_start[i]  = 1'b0;
      ref_report[i] = 1'b0;
    end
    model_active = '0;
    model_count  = '0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    test_name = "reset";
    wb_read(`ADR_ACTIVE, d);
    check_active(test_name, '0, d);
    wb_read(`ADR_COUNT, d);
    check_count(test_name, '0, d);

    // Chain a -> b -> c reports on c and feeds the self loop on STE 3
    test_name = "fixed_pattern";
    clear_class_buf();
    add_class_symbol("a");
    program_ste(0, ste_vec_t'(1 << 1), 1'b1, 1'b0);
    clear_class_buf();
    add_class_symbol("b");
    program_ste(1, ste_vec_t'(1 << 2), 1'b0, 1'b0);
    clear_class_buf();
    add_class_symbol("c");
    program_ste(2, ste_vec_t'(1 << 3), 1'b0, 1'b1);
    clear_class_buf();
    add_class_symbol("a");
    add_class_symbol("b");
    add_class_symbol("c");
    program_ste(3, ste_vec_t'(1 << 3), 1'b0, 1'b0);
    for (int n = 0; n < N_FIXED; n++) begin
      step_and_check(symbol_t'(fixed_stream[n]));
    end
    test_name = "fixed_count";
    wb_read(`ADR_COUNT, d);
    check_count(test_name, model_count, d);

    test_name = "clear";
    wb_write(`ADR_CLEAR, '0);
    model_active = '0;
    model_count  = '0;
    wb_read(`ADR_ACTIVE, d);
    check_active(test_name, '0, d);
    wb_read(`ADR_COUNT, d);
    check_count(test_name, '0, d);
    test_name = "clear_restart";
    step_and_check("a");

    test_name = "random";
    for (int i = 0; i < `N_STE; i++) begin
      for (int k = 0; k < `CLASS_WORDS; k++) begin
        r = $random(seed);
        cfg_write(i, k, r);
      end
      r = $random(seed);
      cfg_write(i, `OFS_SUCC, r);
      r = $random(seed);
      cfg_write(i, `OFS_FLAGS, r & 32'h3);
    end
    for (int n = 0; n < N_RAND; n++) begin
      pick = $unsigned($random(seed)) % 4;
      step_and_check(sym_pool[pick]);
    end
    test_name = "random_count";
    wb_read(`ADR_COUNT, d);
    check_count(test_name, model_count, d);

    repeat (2) @(negedge clk);  // Let the monitor see the last pulse window
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/activation_router.sv ====
`default_nettype none

`include "automaton_params.svh"

module activation_router (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          step,
  input  logic                          clear,
  input  automaton_pkg::ste_vec_t       contrib [`N_STE],
  input  automaton_pkg::ste_vec_t       hit,
  output automaton_pkg::ste_vec_t       active,
  output logic                          report,
  output automaton_pkg::report_count_t  report_count
);

  import automaton_pkg::*;

  ste_vec_t next_active;
  logic     any_hit;

  // Successor routing
  always_comb begin
    next_active = '0;
    for (int i = 0; i < `N_STE; i++) begin
      next_active = next_active | contrib[i];
    end
  end

  assign any_hit = |hit;

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      active       <= '0;
      report       <= 1'b0;
      report_count <= '0;
    end else if (step) begin
      active <= next_active;
      report <= any_hit;
      if (any_hit) begin
        report_count <= report_count + 1'b1;  // Wraps
      end
    end else begin
      report <= 1'b0;  // Single cycle pulse
    end
  end

endmodule

`default_nettype wire

// ==== hw/automaton_params.svh ====
`ifndef AUTOMATON_PARAMS_SVH
`define AUTOMATON_PARAMS_SVH

// Array and datapath sizes
`define N_STE         8
`define SYMBOL_W      8
`define CLASS_WORDS   8      // 256 symbols in 32-bit words
`define WB_ADR_W      10     // Word address
`define WB_DATA_W     32
`define REPORT_CNT_W  16

// Per-STE configuration block
`define STE_STRIDE    16
`define OFS_SUCC      4'd8   // Successor mask
`define OFS_FLAGS     4'd9   // Bit 0 start, bit 1 report

`define FLAG_START    0
`define FLAG_REPORT   1

// Control region, above all STE blocks
`define ADR_SYMBOL    10'h200  // Write steps the automaton
`define ADR_ACTIVE    10'h201
`define ADR_COUNT     10'h202
`define ADR_CLEAR     10'h203

`endif

// ==== hw/automaton_pkg.sv ====
`default_nettype none

`include "automaton_params.svh"

package automaton_pkg;

  typedef logic [`N_STE-1:0]        ste_vec_t;       // One bit per STE
  typedef logic [`SYMBOL_W-1:0]     symbol_t;
  typedef logic [`WB_ADR_W-1:0]     wb_adr_t;
  typedef logic [`WB_DATA_W-1:0]    wb_data_t;       // Also one class word
  typedef logic [$clog2(`N_STE)-1:0] ste_idx_t;
  typedef logic [`REPORT_CNT_W-1:0] report_count_t;

  // Slave handshake, ack is the BUS_ACK state itself
  typedef enum logic {
    BUS_IDLE,
    BUS_ACK
  } bus_state_t;

endpackage

`default_nettype wire

// ==== hw/automaton_top.sv ====
`default_nettype none

`include "automaton_params.svh"

module automaton_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     cyc,
  input  logic                     stb,
  input  logic                     we,
  input  automaton_pkg::wb_adr_t   adr,
  input  automaton_pkg::wb_data_t  dat_w,
  output automaton_pkg::wb_data_t  dat_r,
  output logic                     ack,
  output logic                     report
);

  import automaton_pkg::*;

  logic          cfg_we;
  ste_idx_t      cfg_ste;
  logic [3:0]    cfg_ofs;
  wb_data_t      cfg_data;
  symbol_t       symbol;
  logic          step;
  logic          clear;
  ste_vec_t      active;
  report_count_t report_count;
  ste_vec_t      contrib [`N_STE];
  ste_vec_t      hit;

  wb_config_port port_i (
    .clk          (clk),
    .rst          (rst),
    .cyc          (cyc),
    .stb          (stb),
    .we           (we),
    .adr          (adr),
    .dat_w        (dat_w),
    .dat_r        (dat_r),
    .ack          (ack),
    .cfg_we       (cfg_we),
    .cfg_ste      (cfg_ste),
    .cfg_ofs      (cfg_ofs),
    .cfg_data     (cfg_data),
    .symbol       (symbol),
    .step         (step),
    .clear        (clear),
    .active       (active),
    .report_count (report_count)
  );

  // One cell per STE, each sees the shared config bus
  for (genvar g = 0; g < `N_STE; g++) begin : g_ste
    ste_cell #(
      .STE_ID (g)
    ) cell_i (
      .clk      (clk),
      .rst      (rst),
      .cfg_we   (cfg_we),
      .cfg_ste  (cfg_ste),
      .cfg_ofs  (cfg_ofs),
      .cfg_data (cfg_data),
      .symbol   (symbol),
      .active   (active[g]),
      .contrib  (contrib[g]),
      .hit      (hit[g])
    );
  end

  activation_router router_i (
    .clk          (clk),
    .rst          (rst),
    .step         (step),
    .clear        (clear),
    .contrib      (contrib),
    .hit          (hit),
    .active       (active),
    .report       (report),
    .report_count (report_count)
  );

endmodule

`default_nettype wire

// ==== hw/ste_cell.sv ====
`default_nettype none

`include "automaton_params.svh"

module ste_cell #(
  parameter int STE_ID = 0
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     cfg_we,
  input  automaton_pkg::ste_idx_t  cfg_ste,
  input  logic [3:0]               cfg_ofs,
  input  automaton_pkg::wb_data_t  cfg_data,
  input  automaton_pkg::symbol_t   symbol,
  input  logic                     active,
  output automaton_pkg::ste_vec_t  contrib,
  output logic                     hit
);

  import automaton_pkg::*;

  localparam int WORD_BITS = $clog2(`CLASS_WORDS);
  localparam int BIT_BITS  = $clog2(`WB_DATA_W);

  wb_data_t class_q [`CLASS_WORDS];  // Word k bit b is symbol 32k+b
  ste_vec_t succ_q;
  logic     start_q;
  logic     report_q;
  logic     sel;
  logic     class_bit;
  logic     match;

  assign sel = cfg_we && (cfg_ste == ste_idx_t'(STE_ID));

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < `CLASS_WORDS; k++) begin
        class_q[k] <= '0;
      end
      succ_q   <= '0;
      start_q  <= 1'b0;
      report_q <= 1'b0;
    end else if (sel) begin
      if (cfg_ofs < `CLASS_WORDS) begin
        class_q[cfg_ofs[WORD_BITS-1:0]] <= cfg_data;
      end else if (cfg_ofs == `OFS_SUCC) begin
        succ_q <= cfg_data[`N_STE-1:0];
      end else if (cfg_ofs == `OFS_FLAGS) begin
        start_q  <= cfg_data[`FLAG_START];
        report_q <= cfg_data[`FLAG_REPORT];
      end
    end
  end

  // Upper symbol bits pick the word, lower bits the bit within it
  assign class_bit = class_q[symbol[`SYMBOL_W-1 -: WORD_BITS]][symbol[BIT_BITS-1:0]];

  // Start STEs are always enabled
  assign match   = (active || start_q) && class_bit;
  assign contrib = match ? succ_q : '0;
  assign hit     = match && report_q;

endmodule

`default_nettype wire

// ==== hw/wb_config_port.sv ====
`default_nettype none

`include "automaton_params.svh"

module wb_config_port (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          cyc,
  input  logic                          stb,
  input  logic                          we,
  input  automaton_pkg::wb_adr_t        adr,
  input  automaton_pkg::wb_data_t       dat_w,
  output automaton_pkg::wb_data_t       dat_r,
  output logic                          ack,
  output logic                          cfg_we,
  output automaton_pkg::ste_idx_t       cfg_ste,
  output logic [3:0]                    cfg_ofs,
  output automaton_pkg::wb_data_t       cfg_data,
  output automaton_pkg::symbol_t        symbol,
  output logic                          step,
  output logic                          clear,
  input  automaton_pkg::ste_vec_t       active,
  input  automaton_pkg::report_count_t  report_count
);

  import automaton_pkg::*;

  localparam int OFS_BITS = $clog2(`STE_STRIDE);
  localparam wb_adr_t STE_REGION_END = wb_adr_t'(`N_STE * `STE_STRIDE);

  bus_state_t state;
  logic       wr_stb;
  logic       rd_stb;
  logic       in_ste_region;

  // One ack per request, never back to back
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= BUS_IDLE;
    end else begin
      case (state)
        BUS_IDLE: begin
          if (cyc && stb) begin
            state <= BUS_ACK;
          end
        end
        BUS_ACK: begin
          state <= BUS_IDLE;
        end
        default: begin
          state <= BUS_IDLE;
        end
      endcase
    end
  end

  assign ack = (state == BUS_ACK);

  // Master holds adr, we and dat_w until ack, so decode in the ack cycle
  assign wr_stb        = ack && we;
  assign rd_stb        = ack && !we;
  assign in_ste_region = (adr < STE_REGION_END);

  assign cfg_we   = wr_stb && in_ste_region;
  assign cfg_ste  = adr[OFS_BITS +: $bits(ste_idx_t)];
  assign cfg_ofs  = adr[OFS_BITS-1:0];
  assign cfg_data = dat_w;

  assign symbol = dat_w[`SYMBOL_W-1:0];
  assign step   = wr_stb && (adr == `ADR_SYMBOL);
  assign clear  = wr_stb && (adr == `ADR_CLEAR);

  // Status readback, everything else reads zero
  always_comb begin
    dat_r = '0;
    if (rd_stb) begin
      case (adr)
        `ADR_ACTIVE: dat_r = wb_data_t'(active);
        `ADR_COUNT:  dat_r = wb_data_t'(report_count);
        default:     dat_r = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+hw
hw/automaton_pkg.sv
hw/wb_config_port.sv
hw/ste_cell.sv
hw/activation_router.sv
hw/automaton_top.sv
bench/automaton_tb.sv
